/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bicubic
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/100ps -Wno-fatal -j 0
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

# build, run, and fail unless the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -F -- '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* list.f */
src/bicubic_pkg.sv
src/frac_divider.sv
src/frac_table.sv
src/cubic_engine.sv
src/window_buf.sv
src/bicubic_ctrl.sv
src/bicubic_top.sv
verification/tb_mem.sv
verification/tb_bicubic.sv

/* src/bicubic_ctrl.sv */
module bicubic_ctrl (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic [bicubic_pkg::COORD_W-1:0] v0_i,
    input  logic [bicubic_pkg::COORD_W-1:0] h0_i,
    input  logic [bicubic_pkg::SRC_W-1:0]   sw_i,
    input  logic [bicubic_pkg::SRC_W-1:0]   sh_i,
    input  logic [bicubic_pkg::TGT_W-1:0]   tw_i,
    input  logic [bicubic_pkg::TGT_W-1:0]   th_i,
    input  logic [bicubic_pkg::TGT_W-1:0]   col_i,
    input  logic [bicubic_pkg::PIX_W-1:0]   rom_data_i,
    input  bicubic_pkg::div_rsp_t           div_rsp_i,
    input  logic [bicubic_pkg::FRAC_W-1:0]  tab_rdata_i,
    input  logic [bicubic_pkg::PIX_W-1:0]   cubic_res_i,
    input  logic                            cubic_valid_i,
    input  logic [bicubic_pkg::PIX_W-1:0]   win_p_i,
    output bicubic_pkg::rom_req_t           rom_req_o,
    output bicubic_pkg::div_req_t           div_req_o,
    output logic                            tab_we_o,
    output logic [bicubic_pkg::TGT_W-1:0]   tab_addr_o,
    output logic [bicubic_pkg::FRAC_W-1:0]  tab_wdata_o,
    output bicubic_pkg::cubic_in_t          cubic_in_o,
    output logic                            win_push_o,
    output logic [1:0]                      win_sel_o,
    output bicubic_pkg::res_wr_t            res_wr_o,
    output logic                            done_o
);
    import bicubic_pkg::*;

    typedef enum logic [2:0] {
        ST_DIV,
        ST_DWAIT,
        ST_HPASS,
        ST_HWAIT,
        ST_VPASS,
        ST_VWAIT,
        ST_DONE
    } state_t;

    state_t            state;
    logic              col_phase;  // table done, column division next
    logic [TGT_W-1:0]  tab_idx;
    logic [QUOT_W-1:0] qh;
    logic [FRAC_W-1:0] fh;
    logic [TGT_W-1:0]  row;
    logic [QUOT_W-1:0] qv;
    logic [TGT_W-1:0]  rv;
    logic [1:0]        hcnt;       // window line, 0 is k = -1
    logic [2:0]        pcnt;       // 0 start, 1..4 deliver P0..P3
    logic              pass_end;
    logic [10:0]       col_num;
    logic [TGT_W:0]    rv_sum;
    logic [TGT_W:0]    rv_next;
    logic              qv_step;
    logic [ROM_AW-1:0] src_row;
    logic [ROM_AW-1:0] src_col;

    assign pass_end = (pcnt == 3'd4);
    assign col_num  = col_i * (sw_i - 1'b1);

    // incremental form of v * (sh - 1) / (th - 1)
    assign rv_sum  = {1'b0, rv} + sh_i - 1'b1;
    assign qv_step = rv_sum >= ({1'b0, th_i} - 1'b1);
    assign rv_next = qv_step ? rv_sum - th_i + 1'b1 : rv_sum;

    // 4x4 neighbourhood around (qv, qh), offsets -1..2
    assign src_row = v0_i + qv + hcnt - 1'b1;
    assign src_col = h0_i + qh + pcnt[1:0] - 1'b1;

    assign rom_req_o.en   = (state == ST_HPASS) && !pass_end;
    assign rom_req_o.addr = src_row * ROM_AW'(IMG_DIM) + src_col;

    assign div_req_o.start = (state == ST_DIV);
    assign div_req_o.num   = col_phase ? col_num : 11'(tab_idx);
    assign div_req_o.den   = col_phase ? tw_i - 1'b1 : th_i - 1'b1;

    assign tab_we_o    = (state == ST_DWAIT) && div_rsp_i.done && !col_phase;
    assign tab_addr_o  = tab_we_o ? tab_idx : rv;
    assign tab_wdata_o = div_rsp_i.frac;

    // ROM data lags its request by one cycle, so P lines up with pcnt 1..4
    assign cubic_in_o.start   = ((state == ST_HPASS) || (state == ST_VPASS)) && (pcnt == '0);
    assign cubic_in_o.x       = (state == ST_VPASS) ? tab_rdata_i : fh;
    assign cubic_in_o.p_valid = ((state == ST_HPASS) || (state == ST_VPASS)) && (pcnt != '0);
    assign cubic_in_o.p       = (state == ST_VPASS) ? win_p_i : rom_data_i;

    assign win_push_o = (state == ST_HWAIT) && cubic_valid_i;
    assign win_sel_o  = pcnt[1:0] - 1'b1;

    assign res_wr_o.we   = (state == ST_VWAIT) && cubic_valid_i;
    assign res_wr_o.row  = row;
    assign res_wr_o.col  = col_i;
    assign res_wr_o.data = cubic_res_i;

    assign done_o = (state == ST_DONE);

    always_ff @(posedge CLK) begin
        if (RST) begin
            state     <= ST_DIV;
            col_phase <= 1'b0;
            tab_idx   <= '0;
            row       <= '0;
            qv        <= '0;
            rv        <= '0;
            hcnt      <= '0;
            pcnt      <= '0;
        end else begin
            case (state)
                ST_DIV: begin
                    state <= ST_DWAIT;
                end
                ST_DWAIT: begin
                    if (div_rsp_i.done && col_phase) begin
                        state <= ST_HPASS;  // row 0 fills all four lines
                    end else if (div_rsp_i.done) begin
                        col_phase <= (tab_idx == th_i - 2'd2);
                        tab_idx   <= tab_idx + 1'b1;
                        state     <= ST_DIV;
                    end
                end
                ST_HPASS, ST_VPASS: begin
                    pcnt <= pass_end ? 3'd0 : pcnt + 1'b1;
                    if (pass_end) begin
                        state <= (state == ST_HPASS) ? ST_HWAIT : ST_VWAIT;
                    end
                end
                ST_HWAIT: begin
                    if (cubic_valid_i) begin
                        hcnt  <= hcnt + 1'b1;
                        state <= (hcnt == 2'd3) ? ST_VPASS : ST_HPASS;
                    end
                end
                ST_VWAIT: begin
                    if (cubic_valid_i && (row == th_i - 1'b1)) begin
                        state <= ST_DONE;
                    end else if (cubic_valid_i) begin
                        row <= row + 1'b1;
                        rv  <= rv_next[TGT_W-1:0];
                        if (qv_step) begin
                            qv    <= qv + 1'b1;
                            hcnt  <= 2'd3;      // only line k = 2 is new
                            state <= ST_HPASS;
                        end else begin
                            state <= ST_VPASS;
                        end
                    end
                end
                default: begin
                    state <= ST_DONE;  // hold until reset
                end
            endcase
        end
    end

    // column position, constant for the whole run
    always_ff @(posedge CLK) begin
        if ((state == ST_DWAIT) && div_rsp_i.done && col_phase) begin
            qh <= div_rsp_i.quot;
            fh <= div_rsp_i.frac;
        end
    end

endmodule

/* src/bicubic_pkg.sv */
package bicubic_pkg;

    localparam int IMG_DIM   = 100;  // source picture is square
    localparam int PIX_W     = 8;
    localparam int FRAC_W    = 8;    // Q0.8
    localparam int ROM_AW    = 14;
    localparam int COORD_W   = 7;
    localparam int TGT_W     = 6;
    localparam int SRC_W     = 5;
    localparam int TAB_DEPTH = 64;   // one entry per possible remainder
    localparam int QUOT_W    = 5;

    typedef struct packed {
        logic              en;
        logic [ROM_AW-1:0] addr;
    } rom_req_t;

    typedef struct packed {
        logic             we;
        logic [TGT_W-1:0] row;
        logic [TGT_W-1:0] col;
        logic [PIX_W-1:0] data;
    } res_wr_t;

    // col * (sw - 1) needs 11 bits
    typedef struct packed {
        logic             start;
        logic [10:0]      num;
        logic [TGT_W-1:0] den;
    } div_req_t;

    typedef struct packed {
        logic              done;
        logic [QUOT_W-1:0] quot;
        logic [FRAC_W-1:0] frac;
    } div_rsp_t;

    typedef struct packed {
        logic              start;
        logic [FRAC_W-1:0] x;
        logic              p_valid;
        logic [PIX_W-1:0]  p;
    } cubic_in_t;

endpackage

/* src/bicubic_top.sv */
module bicubic_top (
    input  logic                            CLK,
    input  logic                            RST,
    input  logic [bicubic_pkg::COORD_W-1:0] v0_i,
    input  logic [bicubic_pkg::COORD_W-1:0] h0_i,
    input  logic [bicubic_pkg::SRC_W-1:0]   sw_i,
    input  logic [bicubic_pkg::SRC_W-1:0]   sh_i,
    input  logic [bicubic_pkg::TGT_W-1:0]   tw_i,
    input  logic [bicubic_pkg::TGT_W-1:0]   th_i,
    input  logic [bicubic_pkg::TGT_W-1:0]   col_i,
    input  logic [bicubic_pkg::PIX_W-1:0]   rom_data_i,
    output bicubic_pkg::rom_req_t           rom_req_o,
    output bicubic_pkg::res_wr_t            res_wr_o,
    output logic                            done_o
);
    import bicubic_pkg::*;

    div_req_t          div_req;
    div_rsp_t          div_rsp;
    logic              tab_we;
    logic [TGT_W-1:0]  tab_addr;
    logic [FRAC_W-1:0] tab_wdata;
    logic [FRAC_W-1:0] tab_rdata;
    cubic_in_t         cubic_in;
    logic [PIX_W-1:0]  cubic_res;
    logic              cubic_valid;
    logic              win_push;
    logic [1:0]        win_sel;
    logic [PIX_W-1:0]  win_p;

    bicubic_ctrl i_ctrl (
        .CLK           (CLK),
        .RST           (RST),
        .v0_i          (v0_i),
        .h0_i          (h0_i),
        .sw_i          (sw_i),
        .sh_i          (sh_i),
        .tw_i          (tw_i),
        .th_i          (th_i),
        .col_i         (col_i),
        .rom_data_i    (rom_data_i),
        .div_rsp_i     (div_rsp),
        .tab_rdata_i   (tab_rdata),
        .cubic_res_i   (cubic_res),
        .cubic_valid_i (cubic_valid),
        .win_p_i       (win_p),
        .rom_req_o     (rom_req_o),
        .div_req_o     (div_req),
        .tab_we_o      (tab_we),
        .tab_addr_o    (tab_addr),
        .tab_wdata_o   (tab_wdata),
        .cubic_in_o    (cubic_in),
        .win_push_o    (win_push),
        .win_sel_o     (win_sel),
        .res_wr_o      (res_wr_o),
        .done_o        (done_o)
    );

    frac_divider i_divider (
        .CLK   (CLK),
        .RST   (RST),
        .req_i (div_req),
        .rsp_o (div_rsp)
    );

    // vertical fractions, filled once during init
    frac_table i_table (
        .CLK     (CLK),
        .we_i    (tab_we),
        .addr_i  (tab_addr),
        .wdata_i (tab_wdata),
        .rdata_o (tab_rdata)
    );

    cubic_engine i_engine (
        .CLK         (CLK),
        .RST         (RST),
        .in_i        (cubic_in),
        .res_o       (cubic_res),
        .res_valid_o (cubic_valid)
    );

    window_buf i_window (
        .CLK    (CLK),
        .RST    (RST),
        .push_i (win_push),
        .data_i (cubic_res),
        .sel_i  (win_sel),
        .p_o    (win_p)
    );

endmodule

/* src/cubic_engine.sv */
module cubic_engine (
    input  logic                          CLK,
    input  logic                          RST,
    input  bicubic_pkg::cubic_in_t        in_i,
    output logic [bicubic_pkg::PIX_W-1:0] res_o,
    output logic                          res_valid_o
);
    import bicubic_pkg::*;

    logic [FRAC_W-1:0]         x_q;
    logic [FRAC_W-1:0]         x2_q;
    logic [FRAC_W-1:0]         x3_q;
    logic [2*FRAC_W-1:0]       x2_raw;
    logic [2*FRAC_W-1:0]       x3_raw;
    logic [3:0][PIX_W-1:0]     p_q;     // [0] is P0 once full
    logic [1:0]                p_cnt;
    logic                      p_full;
    logic                      sum_vld;
    logic signed [11:0]        p0;
    logic signed [11:0]        p1;
    logic signed [11:0]        p2;
    logic signed [11:0]        p3;
    logic signed [11:0]        a;
    logic signed [11:0]        b;
    logic signed [11:0]        c;
    logic signed [11:0]        d;
    logic signed [21:0]        sum_d;
    logic signed [21:0]        sum_q;
    logic signed [12:0]        shifted;

    // powers rounded to Q0.8
    assign x2_raw = x_q * x_q + 16'd128;
    assign x3_raw = x2_q * x_q + 16'd128;

    assign p0 = {4'd0, p_q[0]};
    assign p1 = {4'd0, p_q[1]};
    assign p2 = {4'd0, p_q[2]};
    assign p3 = {4'd0, p_q[3]};

    // Catmull-Rom coefficients, all scaled by 2
    assign a = -p0 + 12'sd3 * p1 - 12'sd3 * p2 + p3;
    assign b = 12'sd2 * p0 - 12'sd5 * p1 + 12'sd4 * p2 - p3;
    assign c = p2 - p0;
    assign d = 12'sd2 * p1;

    assign sum_d = a * $signed({1'b0, x3_q}) + b * $signed({1'b0, x2_q})
                 + c * $signed({1'b0, x_q}) + d * 22'sd256 + 22'sd256;

    always_ff @(posedge CLK) begin
        if (RST) begin
            p_cnt   <= '0;
            p_full  <= 1'b0;
            sum_vld <= 1'b0;
        end else begin
            p_full  <= in_i.p_valid && (p_cnt == 2'd3);
            sum_vld <= p_full;
            if (in_i.start) begin
                p_cnt <= '0;
            end else if (in_i.p_valid) begin
                p_cnt <= p_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (in_i.start) begin
            x_q <= in_i.x;
        end
        x2_q <= x2_raw[2*FRAC_W-1:FRAC_W];
        x3_q <= x3_raw[2*FRAC_W-1:FRAC_W];
        if (in_i.p_valid) begin
            p_q <= {in_i.p, p_q[3:1]};
        end
        if (p_full) begin
            sum_q <= sum_d;
        end
    end

    // drop the extra scale of 2 and Q0.8, then clamp to a pixel
    always_comb begin
        shifted = 13'(sum_q >>> 9);
        if (shifted < 13'sd0) begin
            res_o = '0;
        end else if (shifted > 13'sd255) begin
            res_o = '1;
        end else begin
            res_o = shifted[PIX_W-1:0];
        end
    end

    assign res_valid_o = sum_vld;

endmodule

/* src/frac_divider.sv */
module frac_divider (
    input  logic                  CLK,
    input  logic                  RST,
    input  bicubic_pkg::div_req_t req_i,
    output bicubic_pkg::div_rsp_t rsp_o
);
    import bicubic_pkg::*;

    logic [QUOT_W+FRAC_W-1:0] shreg;  // dividend bits out, quotient bits in
    logic [TGT_W-1:0]         rem;
    logic [TGT_W-1:0]         den;
    logic [3:0]               cnt;
    logic                     done;
    logic                     load;
    logic [TGT_W:0]           trial;
    logic [TGT_W:0]           rem_next;
    logic                     fits;

    assign load     = req_i.start && (cnt == '0);
    assign trial    = {rem, shreg[QUOT_W+FRAC_W-1]};
    assign fits     = trial >= {1'b0, den};
    assign rem_next = fits ? trial - {1'b0, den} : trial;  // restoring step

    always_ff @(posedge CLK) begin
        if (RST) begin
            cnt  <= '0;
            done <= 1'b0;
        end else begin
            done <= (cnt == 4'd1);
            if (load) begin
                cnt <= 4'(QUOT_W + FRAC_W);
            end else if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (load) begin
            {rem, shreg} <= {req_i.num, {FRAC_W{1'b0}}};  // num * 256
            den          <= req_i.den;
        end else if (cnt != '0) begin
            rem   <= rem_next[TGT_W-1:0];
            shreg <= {shreg[QUOT_W+FRAC_W-2:0], fits};
        end
    end

    assign rsp_o.done = done;
    assign rsp_o.quot = shreg[QUOT_W+FRAC_W-1:FRAC_W];
    assign rsp_o.frac = shreg[FRAC_W-1:0];

endmodule

/* src/frac_table.sv */
module frac_table (
    input  logic                           CLK,
    input  logic                           we_i,
    input  logic [bicubic_pkg::TGT_W-1:0]  addr_i,
    input  logic [bicubic_pkg::FRAC_W-1:0] wdata_i,
    output logic [bicubic_pkg::FRAC_W-1:0] rdata_o
);
    import bicubic_pkg::*;

    // entry r holds the Q0.8 fraction of r / (th - 1)
    logic [FRAC_W-1:0] mem [TAB_DEPTH];

    always_ff @(posedge CLK) begin
        if (we_i) begin
            mem[addr_i] <= wdata_i;
        end
    end

    assign rdata_o = mem[addr_i];  // async read

endmodule

/* src/window_buf.sv */
module window_buf (
    input  logic                          CLK,
    input  logic                          RST,
    input  logic                          push_i,
    input  logic [bicubic_pkg::PIX_W-1:0] data_i,
    input  logic [1:0]                    sel_i,
    output logic [bicubic_pkg::PIX_W-1:0] p_o
);
    import bicubic_pkg::*;

    // horizontal results of source lines qv-1..qv+2, oldest in [0]
    logic [3:0][PIX_W-1:0] line_q;

    always_ff @(posedge CLK) begin
        if (RST) begin
            line_q <= '0;
        end else if (push_i) begin
            line_q <= {data_i, line_q[3:1]};  // new line enters at the top
        end
    end

    assign p_o = line_q[sel_i];

endmodule

/* verification/tb_bicubic.sv */
module tb_bicubic;
    timeunit 1ns;
    timeprecision 100ps;
    import bicubic_pkg::*;

    typedef struct packed {
        int v0;
        int h0;
        int sw;
        int sh;
        int tw;
        int th;
        int col;
    } geom_t;

    logic               CLK = 1'b0;
    logic               RST;
    logic [COORD_W-1:0] v0;
    logic [COORD_W-1:0] h0;
    logic [SRC_W-1:0]   sw;
    logic [SRC_W-1:0]   sh;
    logic [TGT_W-1:0]   tw;
    logic [TGT_W-1:0]   th;
    logic [TGT_W-1:0]   col;
    logic [PIX_W-1:0]   rom_data;
    rom_req_t           rom_req;
    res_wr_t            res_wr;
    logic               done;

    logic [31:0]        lfsr;
    logic [PIX_W-1:0]   img [IMG_DIM*IMG_DIM];  // copy of the ROM for the model
    geom_t              g;                      // geometry of the current run
    int                 exp_qh;
    int                 exp_qv [TAB_DEPTH];
    int                 exp_data [TAB_DEPTH];
    int                 wr_count;
    logic               done_seen;
    logic               rst_q = 1'b0;

    always #20 CLK = ~CLK;

    bicubic_top i_bicubic_top (
        .CLK        (CLK),
        .RST        (RST),
        .v0_i       (v0),
        .h0_i       (h0),
        .sw_i       (sw),
        .sh_i       (sh),
        .tw_i       (tw),
        .th_i       (th),
        .col_i      (col),
        .rom_data_i (rom_data),
        .rom_req_o  (rom_req),
        .res_wr_o   (res_wr),
        .done_o     (done)
    );

    tb_mem i_mem (
        .CLK        (CLK),
        .rom_req_i  (rom_req),
        .res_wr_i   (res_wr),
        .rom_data_o (rom_data)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic value_error(input string name, input int expected, input int actual);
        fail_now($sformatf("error at %0t: %s expected %0d, actual %0d",
                           $time, name, expected, actual));
    endtask

    // Galois LFSR, one step per bit
    function automatic int take_bits(input int n);
        int   val;
        int   i;
        logic lsb;
        val = 0;
        for (i = 0; i < n; i++) begin
            lsb  = lfsr[0];
            lfsr = lfsr >> 1;
            if (lsb) begin
                lfsr = lfsr ^ 32'h8020_0003;  // x^32 + x^22 + x^2 + x + 1
            end
            val = (val << 1) | int'(lsb);
        end
        return val;
    endfunction

    // Catmull-Rom in Q0.8, coefficients carry a factor of 2
    function automatic int cubic_ref(input int p0, input int p1, input int p2, input int p3,
                                     input int x);
        int x2;
        int x3;
        int sum;
        x2  = (x * x + 128) >> 8;
        x3  = (x2 * x + 128) >> 8;
        sum = (-p0 + 3 * p1 - 3 * p2 + p3) * x3
            + (2 * p0 - 5 * p1 + 4 * p2 - p3) * x2
            + (p2 - p0) * x + 2 * p1 * 256 + 256;
        sum = sum >>> 9;
        return (sum < 0) ? 0 : (sum > 255) ? 255 : sum;
    endfunction

    function automatic int pix(input int r, input int c);
        return int'(img[(g.v0 + r) * IMG_DIM + g.h0 + exp_qh + c]);
    endfunction

    task automatic build_expected();
        int n;
        int fh;
        int qv;
        int fv;
        int v;
        int k;
        int hres [4];
        n      = g.col * (g.sw - 1);
        exp_qh = n / (g.tw - 1);
        fh     = (n % (g.tw - 1)) * 256 / (g.tw - 1);
        for (v = 0; v < g.th; v++) begin
            qv = v * (g.sh - 1) / (g.th - 1);
            fv = (v * (g.sh - 1) % (g.th - 1)) * 256 / (g.th - 1);
            for (k = 0; k < 4; k++) begin  // source lines qv-1 .. qv+2
                hres[k] = cubic_ref(pix(qv + k - 1, -1), pix(qv + k - 1, 0),
                                    pix(qv + k - 1, 1), pix(qv + k - 1, 2), fh);
            end
            exp_qv[v]   = qv;
            exp_data[v] = cubic_ref(hres[0], hres[1], hres[2], hres[3], fv);
        end
    endtask

    task automatic wait_for_rows(input int limit);
        int cycles;
        cycles = 0;
        while (wr_count < g.th) begin
            @(posedge CLK);
            cycles++;
            assert (cycles < limit) else fail_now("timeout: not every row was written");
        end
    endtask

    task automatic wait_for_done(input int limit);
        int cycles;
        cycles = 0;
        while (!done) begin
            @(posedge CLK);
            cycles++;
            assert (cycles < limit) else fail_now("timeout: done_o did not rise after the last row");
        end
    endtask

    task automatic check_result_mem();
        int r;
        for (r = 0; r < g.th; r++) begin
            assert (i_mem.res[r][g.col] == exp_data[r])
                else value_error($sformatf("result memory row %0d", r), exp_data[r],
                                 i_mem.res[r][g.col]);
        end
    endtask

    // mode 0 random column, 1 first column, 2 last column with sh = th
    task automatic pick_and_run(input int mode);
        @(posedge CLK);
        RST <= 1'b1;
        @(posedge CLK);
        g.th  = (mode == 2) ? 2 + take_bits(5) % 30 : 2 + take_bits(6) % 62;
        g.sh  = (mode == 2) ? g.th : 1 + take_bits(5) % ((g.th < 31) ? g.th : 31);
        g.tw  = 2 + take_bits(6) % 62;
        g.sw  = 1 + take_bits(5) % ((g.tw < 31) ? g.tw : 31);
        g.v0  = 1 + take_bits(7) % (98 - g.sh);
        g.h0  = 1 + take_bits(7) % (98 - g.sw);
        g.col = (mode == 0) ? take_bits(6) % g.tw : (mode == 1) ? 0 : g.tw - 1;
        v0    <= COORD_W'(g.v0);
        h0    <= COORD_W'(g.h0);
        sw    <= SRC_W'(g.sw);
        sh    <= SRC_W'(g.sh);
        tw    <= TGT_W'(g.tw);
        th    <= TGT_W'(g.th);
        col   <= TGT_W'(g.col);
        build_expected();
        repeat (2) @(posedge CLK);
        RST <= 1'b0;
        wait_for_rows(100 * g.th + 2000);
        wait_for_done(4);
        repeat (6) @(posedge CLK);  // no write may follow done_o
        check_result_mem();
    endtask

    // output checks, sampled before the edge updates
    always @(posedge CLK) begin
        int dr;
        int dc;
        if (rst_q) begin
            assert (!done) else value_error("done_o", 0, done);
            assert (!rom_req.en) else value_error("rom_req_o.en", 0, rom_req.en);
            assert (!res_wr.we) else value_error("res_wr_o.we", 0, res_wr.we);
        end
        rst_q <= RST;
        if (RST) begin
            wr_count  <= 0;
            done_seen <= 1'b0;
        end else begin
            if (rom_req.en) begin
                dr = int'(rom_req.addr) / IMG_DIM - g.v0 - exp_qv[wr_count];
                dc = int'(rom_req.addr) % IMG_DIM - g.h0 - exp_qh;
                assert (dr >= -1 && dr <= 2 && dc >= -1 && dc <= 2)
                    else fail_now($sformatf("ROM read of address %0d is outside the window of row %0d",
                                            rom_req.addr, wr_count));
            end
            if (res_wr.we) begin
                assert (!done_seen && wr_count < g.th)
                    else fail_now("result write after the last row");
                assert (res_wr.row == wr_count) else value_error("res_wr_o.row", wr_count, res_wr.row);
                assert (res_wr.col == g.col) else value_error("res_wr_o.col", g.col, res_wr.col);
                if (g.col == 0 && wr_count == 0) begin  // both fractions are zero here
                    assert (res_wr.data == img[g.v0 * IMG_DIM + g.h0])
                        else value_error("res_wr_o.data of row 0", img[g.v0 * IMG_DIM + g.h0],
                                         res_wr.data);
                end
                wr_count <= wr_count + 1;
            end
            if (done) begin
                assert (wr_count == g.th) else fail_now("done_o rose before every row was written");
                done_seen <= 1'b1;
            end else begin
                assert (!done_seen) else fail_now("done_o fell before the next reset");
            end
        end
    end

    initial begin
        int a;
        $timeformat(-9, 1, " ns", 0);
        RST  <= 1'b1;
        v0   <= '0;
        h0   <= '0;
        sw   <= '0;
        sh   <= '0;
        tw   <= '0;
        th   <= '0;
        col  <= '0;
        lfsr = 32'h024c_c833;
        for (a = 0; a < IMG_DIM * IMG_DIM; a++) begin
            img[a]       = PIX_W'(take_bits(PIX_W));
            i_mem.rom[a] = img[a];
        end
        pick_and_run(0);
        pick_and_run(1);
        pick_and_run(2);
        $display(">>> PASS");
        $finish;
    end

endmodule

/* verification/tb_mem.sv */
module tb_mem (
    input  logic                          CLK,
    input  bicubic_pkg::rom_req_t         rom_req_i,
    input  bicubic_pkg::res_wr_t          res_wr_i,
    output logic [bicubic_pkg::PIX_W-1:0] rom_data_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import bicubic_pkg::*;

    // source picture in raster order, loaded by the testbench at time 0
    logic [PIX_W-1:0] rom [IMG_DIM*IMG_DIM];
    logic [PIX_W-1:0] res [TAB_DEPTH][TAB_DEPTH];  // [row][col]

    initial begin
        rom_data_o = '0;
    end

    // synchronous ROM, data one cycle after the request
    always @(posedge CLK) begin
        if (rom_req_i.en) begin
            rom_data_o <= rom[rom_req_i.addr];
        end
    end

    // write-only result port, no back-pressure
    always @(posedge CLK) begin
        if (res_wr_i.we) begin
            res[res_wr_i.row][res_wr_i.col] <= res_wr_i.data;
        end
    end

endmodule
